// ==== verilog.f ====
+incdir+testbench
common/uartPkg.sv
uart/baudGen.sv
uart/uartRec.sv
uart/uartTrans.sv
hdl/uartFifo.sv
hdl/uartPeriph.sv
testbench/uartTb.sv

// ==== Makefile ====
# Verilator flow for the uart peripheral and its testbench
# override any variable on the command line, e.g. make sim TOP=uartTb

VERILATOR ?= verilator
FILELIST ?= verilog.f
TOP ?= uartTb
OBJDIR ?= obj_dir
VFLAGS ?= --timing
PASSMSG ?= Test completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

# fails unless the pass message shows up in the simulation output
sim: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

// ==== testbench/uartTbTasks.svh ====
////////////////////////////////////////////////////////////////////////////
// uart testbench helpers
// expected entries, random bytes, typed compares, serial line driver
// and monitor, all timed from the rising edge plus 1 ns
////////////////////////////////////////////////////////////////////////////

`ifndef UART_TB_TASKS_SVH
`define UART_TB_TASKS_SVH

// expected rx entry for a byte sent with a given stop level
function automatic rxEntry_t refFrame(input uartByte_t b, input logic stopVal);
	rxEntry_t e;
	e.data = b;
	e.framingError = !stopVal;			// low stop means a bad frame
	return e;
endfunction

function automatic uartByte_t nextByte();
	lcgState = lcgState * 32'd1664525 + 32'd1013904223;
	return lcgState[23:16];				// upper bits, better spread
endfunction

////////////////////////////////////////////////////////////////////////////
// compares
////////////////////////////////////////////////////////////////////////////

task automatic checkEntry(input rxEntry_t got, input rxEntry_t exp, input string name);
	checkCount++;
	if (got !== exp)
	begin
		$display("error at %0t: %s expected data %h ferr %b, got data %h ferr %b",
			$time, name, exp.data, exp.framingError, got.data, got.framingError);
		errorCount++;
	end
endtask

task automatic checkByte(input uartByte_t got, input uartByte_t exp, input string name);
	checkCount++;
	if (got !== exp)
	begin
		$display("error at %0t: %s expected %h got %h", $time, name, exp, got);
		errorCount++;
	end
endtask

// bits are rxNotEmpty rxFull txFull overrun
task automatic checkStatus(input uartStatus_t got, input uartStatus_t exp);
	checkCount++;
	if (got !== exp)
	begin
		$display("error at %0t: status expected %b got %b", $time, exp, got);
		errorCount++;
	end
endtask

task automatic checkBit(input logic got, input logic exp, input string name);
	checkCount++;
	if (got !== exp)
	begin
		$display("error at %0t: %s expected %b got %b", $time, name, exp, got);
		errorCount++;
	end
endtask

////////////////////////////////////////////////////////////////////////////
// serial line
////////////////////////////////////////////////////////////////////////////

// start, data lsb first, stop, then one idle bit
task automatic sendSerial(input uartByte_t b, input logic stopVal);
	logic [10:0] frame;
	frame = {1'b1, stopVal, b, 1'b0};
	for (int i = 0; i < 11; i++)
	begin
		rxDrive = frame[i];
		repeat (bitCycles) @(posedge clk);
		#1;
	end
endtask

task automatic receiveSerial(output uartByte_t b);
	int waited;
	waited = 0;
	b = '0;
	while (tx !== 1'b0 && waited < edgeTimeout)	// wait for start edge
	begin
		@(posedge clk);
		#1 waited++;
	end
	if (tx !== 1'b0)
	begin
		$display("timeout at %0t: no start bit on tx", $time);
		timeoutCount++;
	end
	else
	begin
		repeat (bitCycles / 2) @(posedge clk);
		#1 checkBit(tx, 1'b0, "tx start");	// middle of start bit
		for (int i = 0; i < dataBits; i++)
		begin
			repeat (bitCycles) @(posedge clk);
			#1 b[i] = tx;
		end
		repeat (bitCycles) @(posedge clk);
		#1 checkBit(tx, 1'b1, "tx stop");
	end
endtask

`endif

// ==== testbench/uartTb.sv ====
////////////////////////////////////////////////////////////////////////////
// uart peripheral testbench
// receive, framing, transmit, loopback and overrun runs against the
// serial peripheral, with a line model on rx and tx
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uartTb;

	import uartPkg::*;

	localparam int bitCycles = 64;		// 16 ticks of 4 clocks
	localparam int edgeTimeout = 4000;
	localparam int flagTimeout = 2000;
	localparam int fillTimeout = 15000;	// 16 frames on loopback

	logic clk, reset;
	logic wrStrobe, rdStrobe;
	uartByte_t wrData;
	rxEntry_t rdData;
	uartStatus_t status;
	logic rxDrive, rxLine, tx;
	logic loopback;						// tx tied back to rx

	int checkCount = 0;
	int errorCount = 0;
	int timeoutCount = 0;
	int testNum = 0;
	int failMark = 0;
	logic [31:0] lcgState = 32'hb6d7_4a94;
	uartByte_t sentQ[$];				// bytes written to the tx side
	rxEntry_t expQ[$];					// entries expected on rdData
	uartByte_t got;

	`include "uartTbTasks.svh"

	uartPeriph #(.clkDiv(4), .fifoDepthLog(4)) dut_i (
		.clk(clk), .reset(reset), .wrStrobe(wrStrobe), .wrData(wrData),
		.rdStrobe(rdStrobe), .rdData(rdData), .status(status),
		.rx(rxLine), .tx(tx)
	);

	assign rxLine = loopback ? tx : rxDrive;

	always #50 clk = !clk;

	// every accepted read is checked against the oldest expected entry
	always @(negedge clk)
	begin
		if (rdStrobe && status.rxNotEmpty)
		begin
			if (expQ.size() == 0)
			begin
				$display("error at %0t: entry read but none was expected", $time);
				errorCount++;
			end
			else
				checkEntry(rdData, expQ.pop_front(), "rdData");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// sequencing helpers, all start and end at rising edge plus 1 ns
	////////////////////////////////////////////////////////////////////////////

	function automatic logic flagOf(input string name);
		if (name == "rxNotEmpty")
			return status.rxNotEmpty;
		else if (name == "rxFull")
			return status.rxFull;
		else
			return status.overrun;
	endfunction

	task automatic waitFlag(input string name, input int limit);
		int waited;
		waited = 0;
		while (!flagOf(name) && waited < limit)
		begin
			@(posedge clk);
			#1 waited++;
		end
		if (!flagOf(name))
		begin
			$display("timeout at %0t: %s did not rise in %0d cycles", $time, name, limit);
			timeoutCount++;
		end
	endtask

	task automatic readEntries(input int n);
		for (int i = 0; i < n; i++)
		begin
			waitFlag("rxNotEmpty", flagTimeout);
			rdStrobe = 1'b1;
			@(posedge clk);
			#1 rdStrobe = 1'b0;
		end
	endtask

	// one byte per cycle, echo entries queued when looped back
	task automatic writeBurst(input int n, input logic expectEcho);
		uartByte_t b;
		for (int i = 0; i < n; i++)
		begin
			b = nextByte();
			sentQ.push_back(b);
			if (expectEcho)
				expQ.push_back(refFrame(b, 1'b1));
			wrStrobe = 1'b1;
			wrData = b;
			@(posedge clk);
			#1;
		end
		wrStrobe = 1'b0;
	endtask

	task automatic endTest(input string name);
		int fails;
		fails = errorCount + timeoutCount - failMark;
		testNum++;
		if (fails == 0)
			$display("test %0d %s: ok", testNum, name);
		else
			$display("test %0d %s: %0d errors", testNum, name, fails);
		failMark = errorCount + timeoutCount;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		uartByte_t b;
		clk = 1'b0;
		reset = 1'b1;
		wrStrobe = 1'b0;
		wrData = '0;
		rdStrobe = 1'b0;
		rxDrive = 1'b1;					// idle line
		loopback = 1'b0;
		repeat (8) @(posedge clk);
		#1 reset = 1'b0;

		checkBit(tx, 1'b1, "tx");
		checkStatus(status, uartStatus_t'(4'b0000));
		endTest("reset");

		for (int i = 0; i < 20; i++)
		begin
			b = nextByte();
			expQ.push_back(refFrame(b, 1'b1));
			sendSerial(b, 1'b1);
			readEntries(1);
		end
		checkStatus(status, uartStatus_t'(4'b0000));
		endTest("receive");

		b = nextByte();
		expQ.push_back(refFrame(b, 1'b0));
		sendSerial(b, 1'b0);			// stop bit held low
		readEntries(1);
		endTest("framing");

		fork
			writeBurst(10, 1'b0);
			for (int i = 0; i < 10; i++)
			begin
				receiveSerial(got);
				checkByte(got, sentQ.pop_front(), "tx byte");
			end
		join
		repeat (bitCycles) @(posedge clk);
		#1 checkBit(tx, 1'b1, "tx idle");
		endTest("transmit");

		sentQ.delete();
		loopback = 1'b1;
		writeBurst(16, 1'b1);
		waitFlag("rxFull", fillTimeout);
		checkStatus(status, uartStatus_t'(4'b1100));
		readEntries(16);
		checkStatus(status, uartStatus_t'(4'b0000));
		endTest("loopback");

		writeBurst(16, 1'b1);			// refill the rx FIFO
		waitFlag("rxFull", fillTimeout);
		loopback = 1'b0;
		sendSerial(nextByte(), 1'b1);	// no room, byte is lost
		waitFlag("overrun", flagTimeout);
		checkStatus(status, uartStatus_t'(4'b1101));
		readEntries(16);
		checkStatus(status, uartStatus_t'(4'b0001));	// overrun sticks
		if (expQ.size() != 0)
		begin
			$display("%0d expected entries were never read", expQ.size());
			errorCount++;
		end
		endTest("overrun");

		$display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== hdl/uartPeriph.sv ====
////////////////////////////////////////////////////////////////////////////
// uart peripheral top level
// tick generator, receiver and transmitter each with a FIFO,
// register-style processor port with status and sticky overrun
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uartPeriph #(
	parameter int clkDiv = 4,			// system clocks per 16x tick
	parameter int fifoDepthLog = 4		// log2 of each FIFO depth
) (
	input logic clk,
	input logic reset,
	input logic wrStrobe,				// queue wrData for sending
	input uartPkg::uartByte_t wrData,
	input logic rdStrobe,				// drop the entry on rdData
	output uartPkg::rxEntry_t rdData,	// oldest received entry
	output uartPkg::uartStatus_t status,
	input logic rx,
	output logic tx
);

	import uartPkg::*;

	logic sTick;
	logic rxDoneTick;
	rxEntry_t rxEntry;
	logic rxEmpty, rxFull;
	logic txEmpty, txFull, txPop;
	uartByte_t txHead;
	logic overrunReg;

	baudGen #(.clkDiv(clkDiv)) baudGen_i (
		.clk(clk), .reset(reset), .sTick(sTick)
	);

	////////////////////////////////////////////////////////////////////////////
	// receive path
	////////////////////////////////////////////////////////////////////////////

	uartRec uartRec_i (
		.clk(clk), .reset(reset), .sTick(sTick), .rx(rx),
		.rxDoneTick(rxDoneTick), .rxEntry(rxEntry)
	);

	uartFifo #(.entry_t(rxEntry_t), .fifoDepthLog(fifoDepthLog)) rxFifo_i (
		.clk(clk), .reset(reset), .push(rxDoneTick), .pushData(rxEntry),
		.pop(rdStrobe), .head(rdData), .empty(rxEmpty), .full(rxFull)
	);

	// lost character, held until reset
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			overrunReg <= 1'b0;
		else if (rxDoneTick && rxFull)
			overrunReg <= 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// transmit path
	////////////////////////////////////////////////////////////////////////////

	uartFifo #(.entry_t(uartByte_t), .fifoDepthLog(fifoDepthLog)) txFifo_i (
		.clk(clk), .reset(reset), .push(wrStrobe), .pushData(wrData),
		.pop(txPop), .head(txHead), .empty(txEmpty), .full(txFull)
	);

	uartTrans uartTrans_i (
		.clk(clk), .reset(reset), .sTick(sTick), .txEmpty(txEmpty),
		.txHead(txHead), .txPop(txPop), .tx(tx)
	);

	assign status = '{rxNotEmpty: !rxEmpty, rxFull: rxFull, txFull: txFull,
		overrun: overrunReg};

endmodule

// ==== hdl/uartFifo.sv ====
////////////////////////////////////////////////////////////////////////////
// first-word-fall-through FIFO
// circular buffer, head visible while not empty, entry type is a parameter
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uartFifo #(
	parameter type entry_t = logic [7:0],	// payload of one slot
	parameter int fifoDepthLog = 4			// depth = 2**fifoDepthLog
) (
	input logic clk,
	input logic reset,
	input logic push,					// write strobe
	input entry_t pushData,
	input logic pop,					// consume head
	output entry_t head,				// oldest entry valid when !empty
	output logic empty,
	output logic full
);

	localparam int depth = 2 ** fifoDepthLog;

	entry_t mem [depth];				// entry storage
	logic [fifoDepthLog:0] wrPtr;		// extra msb tells full from empty
	logic [fifoDepthLog:0] rdPtr;
	logic doPush, doPop;

	// strobes against a full or empty queue are dropped
	assign doPush = push && !full;
	assign doPop = pop && !empty;

	////////////////////////////////////////////////////////////////////////////
	// pointers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;	// head moves next cycle
		end
	end

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr[fifoDepthLog-1:0]] <= pushData;
	end

	////////////////////////////////////////////////////////////////////////////
	// flags and head
	////////////////////////////////////////////////////////////////////////////

	assign empty = (wrPtr == rdPtr);
	assign full = (wrPtr[fifoDepthLog] != rdPtr[fifoDepthLog]) &&
		(wrPtr[fifoDepthLog-1:0] == rdPtr[fifoDepthLog-1:0]);	// wrapped once

	assign head = mem[rdPtr[fifoDepthLog-1:0]];	// fall-through read

endmodule

// ==== uart/uartTrans.sv ====
////////////////////////////////////////////////////////////////////////////
// uart transmitter
// pops bytes from the tx FIFO and sends start, data lsb first and stop,
// every bit timed on the shared 16x tick
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uartTrans (
	input logic clk,
	input logic reset,
	input logic sTick,					// 16x sampling tick
	input logic txEmpty,				// tx FIFO has nothing queued
	input uartPkg::uartByte_t txHead,	// FIFO head, fall-through
	output logic txPop,					// one cycle, head consumed
	output logic tx						// serial line, idle high
);

	import uartPkg::*;

	localparam int sWidth = (sbTick > osTicks) ? $clog2(sbTick) : $clog2(osTicks);
	localparam int nWidth = $clog2(dataBits);

	typedef enum logic [1:0] {stIdle, stStart, stData, stStop} state_t;

	state_t stateReg, stateNext;
	logic [sWidth-1:0] sReg, sNext;		// ticks within current bit
	logic [nWidth-1:0] nReg, nNext;		// data bits sent
	uartByte_t bReg, bNext;				// outgoing shift register
	logic txReg, txNext;				// registered line driver

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= stIdle;
			sReg <= '0;
			nReg <= '0;
			txReg <= 1'b1;				// line idle
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			txReg <= txNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	////////////////////////////////////////////////////////////////////////////
	// FSM, tx changes one cycle after the tick that ends a bit
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txNext = txReg;
		txPop = 1'b0;

		case (stateReg)
			stIdle:
				txPop = sTick && !txEmpty;	// start aligned to a tick
			stStart:
				if (sTick)
				begin
					if (sReg == sWidth'(osTicks - 1))
					begin
						stateNext = stData;
						sNext = '0;
						nNext = '0;
						txNext = bReg[0];	// first data bit
					end
					else
						sNext = sReg + 1'b1;
				end
			stData:
				if (sTick)
				begin
					if (sReg == sWidth'(osTicks - 1))
					begin
						sNext = '0;
						bNext = bReg >> 1;
						if (nReg == nWidth'(dataBits - 1))
						begin
							stateNext = stStop;
							txNext = 1'b1;	// stop level
						end
						else
						begin
							nNext = nReg + 1'b1;
							txNext = bReg[1];	// bit after the one just sent
						end
					end
					else
						sNext = sReg + 1'b1;
				end
			stStop:
				if (sTick)
				begin
					if (sReg == sWidth'(sbTick - 1))
					begin
						stateNext = stIdle;
						txPop = !txEmpty;	// chain next byte, no gap
					end
					else
						sNext = sReg + 1'b1;
				end
			default:
				stateNext = stIdle;
		endcase

		// load head and start the frame, shared by idle and end of stop
		if (txPop)
		begin
			bNext = txHead;
			sNext = '0;
			txNext = 1'b0;				// start bit
			stateNext = stStart;
		end
	end

	assign tx = txReg;

endmodule

// ==== uart/uartRec.sv ====
////////////////////////////////////////////////////////////////////////////
// uart receiver
// oversampling four-state FSM, samples each bit at its middle,
// flags a low stop bit as a framing error
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uartRec (
	input logic clk,
	input logic reset,
	input logic sTick,					// 16x sampling tick
	input logic rx,						// serial line idling high
	output logic rxDoneTick,			// one cycle pulse with a valid entry
	output uartPkg::rxEntry_t rxEntry
);

	import uartPkg::*;

	localparam int sWidth = (sbTick > osTicks) ? $clog2(sbTick) : $clog2(osTicks);
	localparam int nWidth = $clog2(dataBits);

	typedef enum logic [1:0] {stIdle, stStart, stData, stStop} state_t;

	state_t stateReg, stateNext;
	logic [sWidth-1:0] sReg, sNext;		// tick counter within a bit
	logic [nWidth-1:0] nReg, nNext;		// data bit counter
	uartByte_t bReg, bNext;				// shift register
	logic ferrReg, ferrNext;			// framing error of current char
	logic rxMeta, rxSync, rxPrev;		// line synchronizer and edge history

	////////////////////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= stIdle;
			sReg <= '0;
			nReg <= '0;
			ferrReg <= 1'b0;
			rxMeta <= 1'b1;				// line idles high
			rxSync <= 1'b1;
			rxPrev <= 1'b1;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			ferrReg <= ferrNext;
			rxMeta <= rx;				// rx is asynchronous to clk
			rxSync <= rxMeta;
			rxPrev <= rxSync;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;					// received data bits

	////////////////////////////////////////////////////////////////////////////
	// next state logic
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		ferrNext = ferrReg;
		rxDoneTick = 1'b0;

		case (stateReg)
			stIdle:
				if (rxPrev && !rxSync)	// falling edge = start bit
				begin
					stateNext = stStart;
					sNext = '0;
				end
			stStart:
				if (sTick)
				begin
					if (sReg == sWidth'(osTicks/2 - 1))	// middle of start bit
					begin
						stateNext = stData;
						sNext = '0;
						nNext = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			stData:
				if (sTick)
				begin
					if (sReg == sWidth'(osTicks - 1))	// middle of next bit
					begin
						sNext = '0;
						bNext = {rxSync, bReg[dataBits-1:1]};	// lsb first
						if (nReg == nWidth'(dataBits - 1))
							stateNext = stStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			stStop:
				if (sTick)
				begin
					if (sReg == sWidth'(osTicks - 1))
						ferrNext = !rxSync;	// mid of first stop bit
					if (sReg == sWidth'(sbTick - 1))
					begin
						stateNext = stIdle;	// a low line must rise before next start
						rxDoneTick = 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			default:
				stateNext = stIdle;
		endcase
	end

	// flag taken from the next value as sample and done share a tick for one stop bit
	assign rxEntry.data = bReg;
	assign rxEntry.framingError = ferrNext;

endmodule

// ==== uart/baudGen.sv ====
////////////////////////////////////////////////////////////////////////////
// baud tick generator
// divides the system clock down to the 16x oversampling tick
// shared by receiver and transmitter
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module baudGen #(
	parameter int clkDiv = 4			// system clocks per sampling tick
) (
	input logic clk,
	input logic reset,
	output logic sTick				// one cycle high every clkDiv cycles
);

	localparam int cntWidth = (clkDiv > 1) ? $clog2(clkDiv) : 1;

	logic [cntWidth-1:0] cntReg;		// free-running divider
	logic tickReg;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cntReg <= '0;
			tickReg <= 1'b0;
		end
		else if (cntReg == cntWidth'(clkDiv - 1))
		begin
			cntReg <= '0;				// wrap
			tickReg <= 1'b1;			// and fire the tick
		end
		else
		begin
			cntReg <= cntReg + 1'b1;
			tickReg <= 1'b0;
		end
	end

	assign sTick = tickReg;			// tick follows the wrap by one cycle

endmodule

// ==== common/uartPkg.sv ====
////////////////////////////////////////////////////////////////////////////
// uart package
// character format constants and the packed types that the serial
// peripheral passes between its receiver, FIFOs and processor port
////////////////////////////////////////////////////////////////////////////

package uartPkg;

	////////////////////////////////////////////////////////////////////////////
	// character format
	////////////////////////////////////////////////////////////////////////////

	localparam int dataBits = 8;		// data bits per character
	localparam int osTicks = 16;		// sampling ticks per bit period
	localparam int sbTick = 16;			// ticks in stop, 16 = one stop bit

	////////////////////////////////////////////////////////////////////////////
	// payload types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [dataBits-1:0] uartByte_t;	// one data character

	// one received character as queued in the rx FIFO
	typedef struct packed {
		logic framingError;		// stop bit sampled low
		uartByte_t data;		// received byte, bit 0 arrived first
	} rxEntry_t;

	// processor-visible status word
	typedef struct packed {
		logic rxNotEmpty;		// at least one entry waiting
		logic rxFull;			// rx FIFO cannot take more
		logic txFull;			// tx FIFO cannot take more
		logic overrun;			// sticky, a received byte was dropped
	} uartStatus_t;

endpackage
